// File: mipsDecode.f
+incdir+.
mipsDecode_pkg.sv
ctrlDecoder.sv
sysDecoder.sv
decodeStage.sv
mipsDecode.sv
mipsDecode_asserts.sv
mipsDecode_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the mipsDecode testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f mipsDecode.f \
	--top-module mipsDecode_tb \
	-o simv

# the log decides the result, so tee's status is enough here
./obj_dir/simv | tee sim.log

if grep -qx "Verification passed" sim.log; then
	echo "run.sh: simulation PASSED"
	exit 0
else
	echo "run.sh: simulation FAILED"
	exit 1
fi

// File: mipsDecode_tb.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module mipsDecode_tb;

	localparam int numVectors = 2000;
	localparam int resetCycles = 3;
	// a tenth of the vector count as margin
	localparam int timeoutCycles = numVectors + numVectors / 10;

	logic        clk;
	logic        rstN;
	logic [31:0] instr;
	logic        instrValid;
	logic        stall;
	logic        flush;
	mipsDecode_pkg::decodedInstrT decoded;
	mipsDecode_pkg::decodedInstrT expected;
	int cycleCount = 0;

	// encodings the stimulus draws from
	logic [5:0] rFuncts [0:19] = '{
		`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU, `FN_AND, `FN_OR,
		`FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV,
		`FN_JR, `FN_JALR, `FN_SYSCALL, `FN_BREAK
	};
	logic [5:0] plainOps [0:21] = '{
		`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI,
		`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW, `OP_SB, `OP_SH, `OP_SW,
		`OP_BEQ, `OP_BNE, `OP_BLEZ, `OP_BGTZ, `OP_J, `OP_JAL
	};
	logic [4:0] regimmRts [0:3] = '{`RT_BLTZ, `RT_BGEZ, `RT_BLTZAL, `RT_BGEZAL};
	logic [4:0] cop0Rs [0:2] = '{`RS_MFC0, `RS_MTC0, `RS_CO};

	mipsDecode dut_i (
		.clk        (clk),
		.rstN       (rstN),
		.instr      (instr),
		.instrValid (instrValid),
		.stall      (stall),
		.flush      (flush),
		.decoded    (decoded)
	);

	bind decodeStage mipsDecode_asserts asserts_i (
		.clk     (clk),
		.rstN    (rstN),
		.stall   (stall),
		.flush   (flush),
		.decoded (decoded)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: the run did not finish within %0d cycles", timeoutCycles);
			$display("Verification failed");
			$fatal(1, "cycle limit reached");
		end
	end

	// expected datapath controls for one instruction word
	function automatic mipsDecode_pkg::ctrlFieldsT modelCtrl(input logic [31:0] w);
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic       link;
		mipsDecode_pkg::ctrlFieldsT c;
		op = w[31:26];
		rs = w[25:21];
		rt = w[20:16];
		fn = w[5:0];
		link = 1'b0;
		c = '0;
		c.aluOp = mipsDecode_pkg::aluNone;
		c.funct = fn;
		c.writeReg = w[15:11];
		c.regDst = mipsDecode_pkg::dstRd;
		c.branchCond = mipsDecode_pkg::brNone;
		c.signExt = !(op inside {`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI});

		if (op == `OP_RTYPE) begin
			if (fn inside {`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU,
					`FN_AND, `FN_OR, `FN_XOR, `FN_NOR, `FN_SLL, `FN_SRL, `FN_SRA,
					`FN_SLLV, `FN_SRLV, `FN_SRAV}) begin
				c.aluOp = mipsDecode_pkg::aluRtype;
				c.regWrite = 1'b1;
			end else if (fn inside {`FN_JR, `FN_SYSCALL, `FN_BREAK}) begin
				c.aluOp = mipsDecode_pkg::aluRtype;
			end else if (fn == `FN_JALR) begin
				link = 1'b1;
			end else begin
				c.reserved = 1'b1;
			end
		end else if (op inside {`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
				`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI}) begin
			case (op)
				`OP_ADDI:  c.aluOp = mipsDecode_pkg::aluAddi;
				`OP_ADDIU: c.aluOp = mipsDecode_pkg::aluAddiu;
				`OP_SLTI:  c.aluOp = mipsDecode_pkg::aluSlti;
				`OP_SLTIU: c.aluOp = mipsDecode_pkg::aluSltiu;
				`OP_ANDI:  c.aluOp = mipsDecode_pkg::aluAndi;
				`OP_ORI:   c.aluOp = mipsDecode_pkg::aluOri;
				`OP_XORI:  c.aluOp = mipsDecode_pkg::aluXori;
				default:   c.aluOp = mipsDecode_pkg::aluLui;
			endcase
			c.regDst = mipsDecode_pkg::dstRt;
			c.writeReg = rt;
			c.isImm = 1'b1;
			c.regWrite = 1'b1;
		end else if (op inside {`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW}) begin
			c.aluOp = mipsDecode_pkg::aluMem;
			c.regDst = mipsDecode_pkg::dstRt;
			c.writeReg = rt;
			c.isImm = 1'b1;
			c.regWrite = 1'b1;
			c.memRead = 1'b1;
			c.memToReg = 1'b1;
		end else if (op inside {`OP_SB, `OP_SH, `OP_SW}) begin
			c.aluOp = mipsDecode_pkg::aluMem;
			c.isImm = 1'b1;
			c.memWrite = 1'b1;
		end else if (op == `OP_BEQ) begin
			c.branchCond = mipsDecode_pkg::brEq;
		end else if (op == `OP_BNE) begin
			c.branchCond = mipsDecode_pkg::brNe;
		end else if (op == `OP_BLEZ) begin
			c.branchCond = mipsDecode_pkg::brLez;
		end else if (op == `OP_BGTZ) begin
			c.branchCond = mipsDecode_pkg::brGtz;
		end else if (op == `OP_REGIMM) begin
			if (rt inside {`RT_BLTZ, `RT_BLTZAL}) begin
				c.branchCond = mipsDecode_pkg::brLtz;
			end else if (rt inside {`RT_BGEZ, `RT_BGEZAL}) begin
				c.branchCond = mipsDecode_pkg::brGez;
			end else begin
				c.reserved = 1'b1;
			end
			link = (rt inside {`RT_BLTZAL, `RT_BGEZAL});
		end else if (op == `OP_J) begin
			// plain jump, defaults only
		end else if (op == `OP_JAL) begin
			link = 1'b1;
		end else if (op == `OP_COP0) begin
			if (rs == `RS_MFC0) begin
				c.aluOp = mipsDecode_pkg::aluMfc0;
				c.regDst = mipsDecode_pkg::dstRt;
				c.writeReg = rt;
				c.regWrite = 1'b1;
			end else if (rs == `RS_MTC0) begin
				c.aluOp = mipsDecode_pkg::aluMtc0;
			end else if (!(rs == `RS_CO && fn == `FN_ERET)) begin
				c.reserved = 1'b1;
			end
		end else begin
			c.reserved = 1'b1;
		end

		if (link) begin
			c.regDst = mipsDecode_pkg::dstRa;
			c.writeReg = `LINK_REG;
			c.regWrite = 1'b1;
		end
		return c;
	endfunction

	function automatic mipsDecode_pkg::sysFieldsT modelSys(input logic [31:0] w);
		mipsDecode_pkg::sysFieldsT s;
		s.syscall = (w[31:26] == `OP_RTYPE && w[5:0] == `FN_SYSCALL);
		s.brk = (w[31:26] == `OP_RTYPE && w[5:0] == `FN_BREAK);
		s.eret = (w[31:26] == `OP_COP0 && w[25:21] == `RS_CO && w[5:0] == `FN_ERET);
		s.cp0Write = (w[31:26] == `OP_COP0 && w[25:21] == `RS_MTC0);
		s.cp0ToReg = (w[31:26] == `OP_COP0 && w[25:21] == `RS_MFC0);
		return s;
	endfunction

	// 80% kept encodings and the rest raw random words
	function automatic logic [31:0] randomInstr();
		logic [31:0] w;
		int kind;
		w = $urandom();
		if ($urandom_range(0, 99) < 80) begin
			kind = $urandom_range(0, 3);
			case (kind)
				0: begin
					w[31:26] = `OP_RTYPE;
					w[5:0] = rFuncts[5'($urandom_range(0, 19))];
				end
				1: w[31:26] = plainOps[5'($urandom_range(0, 21))];
				2: begin
					w[31:26] = `OP_REGIMM;
					w[20:16] = regimmRts[2'($urandom_range(0, 3))];
				end
				default: begin
					w[31:26] = `OP_COP0;
					w[25:21] = cop0Rs[2'($urandom_range(0, 2))];
					if (w[25:21] == `RS_CO) begin
						w[5:0] = `FN_ERET;
					end
				end
			endcase
		end
		return w;
	endfunction

	// register rule and merge rule at one rising edge
	task automatic modelEdge();
		mipsDecode_pkg::decodedInstrT m;
		if (!rstN || flush) begin
			expected = '0;
		end else if (!stall) begin
			m.valid = instrValid;
			m.ctrl = modelCtrl(instr);
			m.sys = modelSys(instr);
			if (m.ctrl.reserved) begin
				m.ctrl.regWrite = 1'b0;
				m.ctrl.memRead = 1'b0;
				m.ctrl.memWrite = 1'b0;
				m.ctrl.memToReg = 1'b0;
			end
			expected = m;
		end
	endtask

	task automatic checkField(input string name, input logic [7:0] expVal,
			input logic [7:0] actVal);
		assert (actVal === expVal) else begin
			$display("MISMATCH %s expected=0x%02h actual=0x%02h cycle=%0d",
				name, expVal, actVal, cycleCount);
			$display("Verification failed");
			$fatal(1, "decoded field %s differs from the model", name);
		end
	endtask

	task automatic compareOutputs();
		checkField("valid", 8'(expected.valid), 8'(decoded.valid));
		checkField("aluOp", 8'(expected.ctrl.aluOp), 8'(decoded.ctrl.aluOp));
		checkField("funct", 8'(expected.ctrl.funct), 8'(decoded.ctrl.funct));
		checkField("writeReg", 8'(expected.ctrl.writeReg), 8'(decoded.ctrl.writeReg));
		checkField("regDst", 8'(expected.ctrl.regDst), 8'(decoded.ctrl.regDst));
		checkField("regWrite", 8'(expected.ctrl.regWrite), 8'(decoded.ctrl.regWrite));
		checkField("isImm", 8'(expected.ctrl.isImm), 8'(decoded.ctrl.isImm));
		checkField("signExt", 8'(expected.ctrl.signExt), 8'(decoded.ctrl.signExt));
		checkField("memRead", 8'(expected.ctrl.memRead), 8'(decoded.ctrl.memRead));
		checkField("memWrite", 8'(expected.ctrl.memWrite), 8'(decoded.ctrl.memWrite));
		checkField("memToReg", 8'(expected.ctrl.memToReg), 8'(decoded.ctrl.memToReg));
		checkField("branchCond", 8'(expected.ctrl.branchCond), 8'(decoded.ctrl.branchCond));
		checkField("reserved", 8'(expected.ctrl.reserved), 8'(decoded.ctrl.reserved));
		checkField("syscall", 8'(expected.sys.syscall), 8'(decoded.sys.syscall));
		checkField("brk", 8'(expected.sys.brk), 8'(decoded.sys.brk));
		checkField("eret", 8'(expected.sys.eret), 8'(decoded.sys.eret));
		checkField("cp0Write", 8'(expected.sys.cp0Write), 8'(decoded.sys.cp0Write));
		checkField("cp0ToReg", 8'(expected.sys.cp0ToReg), 8'(decoded.sys.cp0ToReg));
	endtask

	task automatic driveRandom();
		instr = randomInstr();
		instrValid = ($urandom_range(0, 1) == 1);
		stall = ($urandom_range(0, 99) < 15);
		flush = ($urandom_range(0, 99) < 5);
	endtask

	// model and DUT both see the edge and the compare waits for NBA to settle
	task automatic runEdge();
		@(posedge clk);
		modelEdge();
		#1;
		compareOutputs();
	endtask

	initial begin
		void'($urandom(98363));
		rstN = 1'b0;
		instr = '0;
		instrValid = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		expected = '0;

		repeat (resetCycles) begin
			runEdge();
		end
		rstN = 1'b1;
		driveRandom();

		repeat (numVectors) begin
			runEdge();
			driveRandom();
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// File: mipsDecode_asserts.sv
`timescale 1ns/1ps

module mipsDecode_asserts (
	input logic                         clk,
	input logic                         rstN,
	input logic                         stall,
	input logic                         flush,
	input mipsDecode_pkg::decodedInstrT decoded
);

	// register comes out of reset empty
	validLowAfterReset: assert property (
		@(posedge clk) !rstN |=> !decoded.valid
	) else $error("valid is high in the cycle after reset");

	memExclusive: assert property (
		@(posedge clk) disable iff (!rstN)
		!(decoded.ctrl.memRead && decoded.ctrl.memWrite)
	) else $error("memRead and memWrite are both high");

	// reserved encodings never write the regfile
	reservedNoWrite: assert property (
		@(posedge clk) disable iff (!rstN)
		decoded.ctrl.reserved |-> !decoded.ctrl.regWrite
	) else $error("reserved instruction has regWrite set");

	stallHolds: assert property (
		@(posedge clk) disable iff (!rstN)
		(stall && !flush) |=> $stable(decoded)
	) else $error("decoded changed on a stalled edge");

endmodule

// File: mipsDecode.sv
`timescale 1ns/1ps

module mipsDecode (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [31:0]                  instr,
	input  logic                         instrValid,
	input  logic                         stall,
	input  logic                         flush,
	output mipsDecode_pkg::decodedInstrT decoded
);

	mipsDecode_pkg::ctrlFieldsT ctrlFields;
	mipsDecode_pkg::sysFieldsT  sysFields;

	ctrlDecoder ctrl_i (
		.instr (instr),
		.ctrl  (ctrlFields)
	);

	sysDecoder sys_i (
		.instr (instr),
		.sys   (sysFields)
	);

	// both decoders feed the D/E register
	decodeStage stage_i (
		.clk        (clk),
		.rstN       (rstN),
		.instrValid (instrValid),
		.stall      (stall),
		.flush      (flush),
		.ctrl       (ctrlFields),
		.sys        (sysFields),
		.decoded    (decoded)
	);

endmodule

// File: decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          instrValid,
	input  logic                          stall,
	input  logic                          flush,
	input  mipsDecode_pkg::ctrlFieldsT    ctrl,
	input  mipsDecode_pkg::sysFieldsT     sys,
	output mipsDecode_pkg::decodedInstrT  decoded
);

	mipsDecode_pkg::decodedInstrT merged;

	always_comb begin
		merged.valid = instrValid;
		merged.ctrl = ctrl;
		merged.sys = sys;
		// reserved instr must not touch regfile or memory
		if (ctrl.reserved) begin
			merged.ctrl.regWrite = 1'b0;
			merged.ctrl.memRead = 1'b0;
			merged.ctrl.memWrite = 1'b0;
			merged.ctrl.memToReg = 1'b0;
		end
	end

	// decode/execute register where flush beats stall
	always_ff @(posedge clk) begin
		if (!rstN || flush) begin
			decoded <= '0;
		end else if (!stall) begin
			decoded <= merged;
		end
	end

endmodule

// File: sysDecoder.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module sysDecoder (
	input  logic [31:0]               instr,
	output mipsDecode_pkg::sysFieldsT sys
);

	logic [5:0] op;
	logic [4:0] rs;
	logic [5:0] fn;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign fn = instr[5:0];

	always_comb begin
		sys = '0;
		case (op)
			`OP_RTYPE: begin
				case (fn)
					`FN_SYSCALL: sys.syscall = 1'b1;
					`FN_BREAK:   sys.brk = 1'b1;
					default: begin
					end
				endcase
			end
			`OP_COP0: begin
				case (rs)
					`RS_MFC0: sys.cp0ToReg = 1'b1;
					`RS_MTC0: sys.cp0Write = 1'b1;
					`RS_CO: begin
						// return from exception
						sys.eret = (fn == `FN_ERET);
					end
					default: begin
					end
				endcase
			end
			default: begin
			end
		endcase
	end

endmodule

// File: ctrlDecoder.sv
`timescale 1ns/1ps
`include "mips_defs.svh"

module ctrlDecoder (
	input  logic [31:0]                instr,
	output mipsDecode_pkg::ctrlFieldsT ctrl
);

	logic [5:0] op;
	logic [5:0] fn;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;

	assign op = instr[31:26];
	assign rs = instr[25:21];
	assign rt = instr[20:16];
	assign rd = instr[15:11];
	assign fn = instr[5:0];

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = mipsDecode_pkg::aluNone;
		ctrl.funct = fn;
		ctrl.writeReg = rd;
		ctrl.regDst = mipsDecode_pkg::dstRd;
		ctrl.branchCond = mipsDecode_pkg::brNone;

		case (op)
			`OP_RTYPE: begin
				case (fn)
					`FN_ADD, `FN_ADDU, `FN_SUB, `FN_SUBU, `FN_SLT, `FN_SLTU,
					`FN_AND, `FN_OR, `FN_XOR, `FN_NOR,
					`FN_SLL, `FN_SRL, `FN_SRA, `FN_SLLV, `FN_SRLV, `FN_SRAV: begin
						ctrl.aluOp = mipsDecode_pkg::aluRtype;
						ctrl.regWrite = 1'b1;
					end
					// no register result
					`FN_JR, `FN_SYSCALL, `FN_BREAK: begin
						ctrl.aluOp = mipsDecode_pkg::aluRtype;
					end
					`FN_JALR: begin
						ctrl.regDst = mipsDecode_pkg::dstRa;
						ctrl.writeReg = `LINK_REG;
						ctrl.regWrite = 1'b1;
					end
					default: ctrl.reserved = 1'b1;
				endcase
			end
			`OP_ADDI, `OP_ADDIU, `OP_SLTI, `OP_SLTIU,
			`OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI: begin
				case (op)
					`OP_ADDI:  ctrl.aluOp = mipsDecode_pkg::aluAddi;
					`OP_ADDIU: ctrl.aluOp = mipsDecode_pkg::aluAddiu;
					`OP_SLTI:  ctrl.aluOp = mipsDecode_pkg::aluSlti;
					`OP_SLTIU: ctrl.aluOp = mipsDecode_pkg::aluSltiu;
					`OP_ANDI:  ctrl.aluOp = mipsDecode_pkg::aluAndi;
					`OP_ORI:   ctrl.aluOp = mipsDecode_pkg::aluOri;
					`OP_XORI:  ctrl.aluOp = mipsDecode_pkg::aluXori;
					default:   ctrl.aluOp = mipsDecode_pkg::aluLui;
				endcase
				ctrl.regDst = mipsDecode_pkg::dstRt;
				ctrl.writeReg = rt;
				ctrl.isImm = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			`OP_LB, `OP_LBU, `OP_LH, `OP_LHU, `OP_LW: begin
				ctrl.aluOp = mipsDecode_pkg::aluMem;
				ctrl.regDst = mipsDecode_pkg::dstRt;
				ctrl.writeReg = rt;
				ctrl.isImm = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
			end
			`OP_SB, `OP_SH, `OP_SW: begin
				ctrl.aluOp = mipsDecode_pkg::aluMem;
				ctrl.isImm = 1'b1;
				ctrl.memWrite = 1'b1;
			end
			`OP_BEQ:  ctrl.branchCond = mipsDecode_pkg::brEq;
			`OP_BNE:  ctrl.branchCond = mipsDecode_pkg::brNe;
			`OP_BLEZ: ctrl.branchCond = mipsDecode_pkg::brLez;
			`OP_BGTZ: ctrl.branchCond = mipsDecode_pkg::brGtz;
			`OP_REGIMM: begin
				case (rt)
					`RT_BLTZ, `RT_BLTZAL: ctrl.branchCond = mipsDecode_pkg::brLtz;
					`RT_BGEZ, `RT_BGEZAL: ctrl.branchCond = mipsDecode_pkg::brGez;
					default: ctrl.reserved = 1'b1;
				endcase
				// the AL forms also link through ra
				if (rt == `RT_BLTZAL || rt == `RT_BGEZAL) begin
					ctrl.regDst = mipsDecode_pkg::dstRa;
					ctrl.writeReg = `LINK_REG;
					ctrl.regWrite = 1'b1;
				end
			end
			`OP_J: begin
			end
			`OP_JAL: begin
				ctrl.regDst = mipsDecode_pkg::dstRa;
				ctrl.writeReg = `LINK_REG;
				ctrl.regWrite = 1'b1;
			end
			`OP_COP0: begin
				case (rs)
					`RS_MFC0: begin
						ctrl.aluOp = mipsDecode_pkg::aluMfc0;
						ctrl.regDst = mipsDecode_pkg::dstRt;
						ctrl.writeReg = rt;
						ctrl.regWrite = 1'b1;
					end
					`RS_MTC0: ctrl.aluOp = mipsDecode_pkg::aluMtc0;
					// only eret survives in the CO group
					`RS_CO: ctrl.reserved = (fn != `FN_ERET);
					default: ctrl.reserved = 1'b1;
				endcase
			end
			default: ctrl.reserved = 1'b1;
		endcase

		// zero extend for the logical immediates
		ctrl.signExt = !(op == `OP_ANDI || op == `OP_ORI || op == `OP_XORI || op == `OP_LUI);
	end

endmodule

// File: mipsDecode_pkg.sv
package mipsDecode_pkg;

	typedef logic [4:0] regIdxT;

	typedef enum logic [3:0] {
		aluRtype,
		aluAddi,
		aluAddiu,
		aluSlti,
		aluSltiu,
		aluAndi,
		aluOri,
		aluXori,
		aluLui,
		aluMem,
		aluMtc0,
		aluMfc0,
		aluNone
	} aluOpT;

	// write register source
	typedef enum logic [1:0] {
		dstRd,
		dstRt,
		dstRa
	} regDstT;

	typedef enum logic [2:0] {
		brNone,
		brEq,
		brNe,
		brLez,
		brGtz,
		brLtz,
		brGez
	} branchCondT;

	typedef struct packed {
		aluOpT      aluOp;
		logic [5:0] funct;
		regIdxT     writeReg;
		regDstT     regDst;
		logic       regWrite;
		logic       isImm;
		logic       signExt;
		logic       memRead;
		logic       memWrite;
		logic       memToReg;
		branchCondT branchCond;
		logic       reserved;
	} ctrlFieldsT;

	typedef struct packed {
		logic syscall;
		logic brk;
		logic eret;
		logic cp0Write;
		logic cp0ToReg;
	} sysFieldsT;

	typedef struct packed {
		logic       valid;
		ctrlFieldsT ctrl;
		sysFieldsT  sys;
	} decodedInstrT;

endpackage

// File: mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// major opcodes in instr[31:26]
`define OP_RTYPE   6'b000000
`define OP_REGIMM  6'b000001
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_BLEZ    6'b000110
`define OP_BGTZ    6'b000111
`define OP_ADDI    6'b001000
`define OP_ADDIU   6'b001001
`define OP_SLTI    6'b001010
`define OP_SLTIU   6'b001011
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_COP0    6'b010000
`define OP_LB      6'b100000
`define OP_LH      6'b100001
`define OP_LW      6'b100011
`define OP_LBU     6'b100100
`define OP_LHU     6'b100101
`define OP_SB      6'b101000
`define OP_SH      6'b101001
`define OP_SW      6'b101011

// funct field in instr[5:0]
`define FN_SLL     6'b000000
`define FN_SRL     6'b000010
`define FN_SRA     6'b000011
`define FN_SLLV    6'b000100
`define FN_SRLV    6'b000110
`define FN_SRAV    6'b000111
`define FN_JR      6'b001000
`define FN_JALR    6'b001001
`define FN_SYSCALL 6'b001100
`define FN_BREAK   6'b001101
`define FN_ERET    6'b011000
`define FN_ADD     6'b100000
`define FN_ADDU    6'b100001
`define FN_SUB     6'b100010
`define FN_SUBU    6'b100011
`define FN_AND     6'b100100
`define FN_OR      6'b100101
`define FN_XOR     6'b100110
`define FN_NOR     6'b100111
`define FN_SLT     6'b101010
`define FN_SLTU    6'b101011

// REGIMM branches select on rt
`define RT_BLTZ    5'b00000
`define RT_BGEZ    5'b00001
`define RT_BLTZAL  5'b10000
`define RT_BGEZAL  5'b10001

// COP0 selects on rs
`define RS_MFC0    5'b00000
`define RS_MTC0    5'b00100
`define RS_CO      5'b10000

`define LINK_REG   5'd31

`endif
